//--- design/tcb_defs.svh
// bus widths, address map, RAM size and UART timing; include wherever these values are needed
`ifndef TCB_DEFS_SVH
`define TCB_DEFS_SVH

//////////////////////////////
// bus widths
//////////////////////////////

`define TCB_ADR_W 16
`define TCB_DAT_W 32
// one enable per data byte
`define TCB_BEN_W 4

// subordinate ports behind the demultiplexer
`define TCB_SPN 3

//////////////////////////////
// address map
//////////////////////////////

// regions are power-of-two sized and aligned
`define TCB_RAM_BASE  16'h0000
`define TCB_RAM_SIZE  16'h0400
`define TCB_TMR_BASE  16'h1000
`define TCB_UART_BASE 16'h2000
`define TCB_PER_SIZE  16'h0010

// RAM words, must cover TCB_RAM_SIZE bytes
`define TCB_RAM_DEPTH 256

// clock cycles per serial bit
`define TCB_BAUD_DIV 4

`endif

//--- design/tcb_pkg.sv
// shared bus types and the UART state encoding, referenced by scoped name from the design
`include "tcb_defs.svh"

package tcb_pkg;

  //////////////////////////////
  // bus fields
  //////////////////////////////

  // byte address
  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

  // data word
  typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

  // byte enables
  typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

  // subordinate index
  // 0 ram, 1 timer, 2 uart
  typedef logic [1:0] tcb_sel_t;

  //////////////////////////////
  // uart transmitter
  //////////////////////////////

  // frame phases, one bit period each except data (8 periods)
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } uart_state_t;

endpackage

//--- design/tcb_decoder.sv
// address decoder, turns a request address into a subordinate index and a hit flag
`include "tcb_defs.svh"

module tcb_decoder (
  input  tcb_pkg::tcb_adr_t adr,
  output tcb_pkg::tcb_sel_t sel,
  output logic              hit
);

  // region match for aligned power-of-two regions
  // low address bits inside the region are masked off
  function automatic logic in_region(
    input tcb_pkg::tcb_adr_t a,
    input tcb_pkg::tcb_adr_t base,
    input tcb_pkg::tcb_adr_t size
  );
    return (a & ~(size - tcb_pkg::tcb_adr_t'(1))) == base;
  endfunction

  //////////////////////////////
  // address map
  //////////////////////////////

  always_comb begin
    // default is a miss, index 0 is harmless
    sel = 2'd0;
    hit = 1'b0;
    if (in_region(adr, `TCB_RAM_BASE, `TCB_RAM_SIZE)) begin
      sel = 2'd0;
      hit = 1'b1;
    end else if (in_region(adr, `TCB_TMR_BASE, `TCB_PER_SIZE)) begin
      sel = 2'd1;
      hit = 1'b1;
    end else if (in_region(adr, `TCB_UART_BASE, `TCB_PER_SIZE)) begin
      sel = 2'd2;
      hit = 1'b1;
    end
  end

endmodule

//--- design/tcb_demultiplexer.sv
// bus demultiplexer, steers one manager port to SPN subordinate ports by a decoded index
module tcb_demultiplexer #(
  parameter int unsigned SPN = 3
) (
  input  logic              sub,
  input  logic              rst_n,
  // decoded select
  input  tcb_pkg::tcb_sel_t sel,
  input  logic              hit,
  // manager side
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  output logic              rdy,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              err,
  // subordinate side
  output logic              spn_vld [SPN],
  output logic              spn_wen [SPN],
  output tcb_pkg::tcb_adr_t spn_adr [SPN],
  output tcb_pkg::tcb_ben_t spn_ben [SPN],
  output tcb_pkg::tcb_dat_t spn_wdt [SPN],
  input  logic              spn_rdy [SPN],
  input  tcb_pkg::tcb_dat_t spn_rdt [SPN]
);

  logic              trn;
  // index of the port owning the pending response
  tcb_pkg::tcb_sel_t rsp_sel;
  logic              miss;

  //////////////////////////////
  // request path
  //////////////////////////////

  for (genvar i = 0; i < SPN; i++) begin : gen_req
    // valid only toward the selected port
    assign spn_vld[i] = vld & hit & (sel == tcb_pkg::tcb_sel_t'(i));
    // payload is shared
    assign spn_wen[i] = wen;
    assign spn_adr[i] = adr;
    assign spn_ben[i] = ben;
    assign spn_wdt[i] = wdt;
  end

  // ready from the addressed port, a miss completes at once
  always_comb begin
    rdy = 1'b1;
    if (hit) begin
      rdy = 1'b0;
      for (int i = 0; i < SPN; i++) begin
        if (sel == tcb_pkg::tcb_sel_t'(i)) rdy = spn_rdy[i];
      end
    end
  end

  assign trn = vld & rdy;

  //////////////////////////////
  // response path
  //////////////////////////////

  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rsp_sel <= '0;
      miss    <= 1'b0;
    end else begin
      // err lasts only the cycle after the transfer
      miss <= trn & ~hit;
      if (trn) rsp_sel <= sel;
    end
  end

  // read data of the port that took the last transfer
  always_comb begin
    rdt = '0;
    for (int i = 0; i < SPN; i++) begin
      if (rsp_sel == tcb_pkg::tcb_sel_t'(i)) rdt = spn_rdt[i];
    end
  end

  assign err = miss;

endmodule

//--- design/tcb_ram.sv
// word RAM subordinate with byte enables; read data arrives one cycle after the transfer
`include "tcb_defs.svh"

module tcb_ram (
  input  logic              sub,
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  output logic              rdy,
  output tcb_pkg::tcb_dat_t rdt
);

  // word index bits
  localparam int unsigned AW = $clog2(`TCB_RAM_DEPTH);
  // bytes per word
  localparam int unsigned BN = $bits(tcb_pkg::tcb_ben_t);

  tcb_pkg::tcb_dat_t mem [`TCB_RAM_DEPTH];
  logic [AW-1:0]     idx;

  // drop the byte offset
  assign idx = adr[AW+1:2];

  // never stalls
  assign rdy = 1'b1;

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge sub) begin
    if (vld) begin
      if (wen) begin
        // only enabled bytes change
        for (int b = 0; b < BN; b++) begin
          if (ben[b]) mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end else begin
        rdt <= mem[idx];
      end
    end
  end

endmodule

//--- design/tcb_timer.sv
// compare timer subordinate; counter wraps at CMP, sets a sticky flag and drives irq
module tcb_timer (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  output logic              rdy,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              irq
);

  // register offsets, word index
  localparam logic [1:0] OFS_CTRL = 2'd0;
  localparam logic [1:0] OFS_CMP  = 2'd1;
  localparam logic [1:0] OFS_CNT  = 2'd2;
  localparam logic [1:0] OFS_STS  = 2'd3;

  logic              wr;
  logic              rd;
  logic [1:0]        ofs;
  logic              en;
  tcb_pkg::tcb_dat_t cmp;
  tcb_pkg::tcb_dat_t cnt;
  logic              flag;
  logic              match;

  // byte-wise merge of write data
  function automatic tcb_pkg::tcb_dat_t merge(
    input tcb_pkg::tcb_dat_t old_word,
    input tcb_pkg::tcb_dat_t new_word,
    input tcb_pkg::tcb_ben_t be
  );
    tcb_pkg::tcb_dat_t res;
    res = old_word;
    for (int b = 0; b < $bits(tcb_pkg::tcb_ben_t); b++) begin
      if (be[b]) res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // always ready
  assign rdy   = 1'b1;
  assign ofs   = adr[3:2];
  assign wr    = vld & wen;
  assign rd    = vld & ~wen;
  assign match = (cnt == cmp);

  //////////////////////////////
  // counter and flag
  //////////////////////////////

  always_ff @(posedge sub) begin
    if (!rst_n) begin
      en   <= 1'b0;
      cmp  <= '1;
      cnt  <= '0;
      flag <= 1'b0;
    end else begin
      if (en) cnt <= match ? '0 : cnt + tcb_pkg::tcb_dat_t'(1);
      // bus writes override the step
      if (wr && ofs == OFS_CTRL && ben[0]) en <= wdt[0];
      if (wr && ofs == OFS_CMP) cmp <= merge(cmp, wdt, ben);
      if (wr && ofs == OFS_CNT) cnt <= merge(cnt, wdt, ben);
      // write 1 to clear
      if (wr && ofs == OFS_STS && ben[0] && wdt[0]) flag <= 1'b0;
      // a fresh match is never lost
      if (en && match) flag <= 1'b1;
    end
  end

  assign irq = flag;

  // read data, registered on the transfer
  always_ff @(posedge sub) begin
    if (rd) begin
      case (ofs)
        OFS_CTRL: rdt <= tcb_pkg::tcb_dat_t'(en);
        OFS_CMP:  rdt <= cmp;
        OFS_CNT:  rdt <= cnt;
        default:  rdt <= tcb_pkg::tcb_dat_t'(flag);
      endcase
    end
  end

endmodule

//--- design/tcb_uart_tx.sv
// 8N1 UART transmitter subordinate; a TXDATA write stalls on rdy while a frame is in flight
`include "tcb_defs.svh"

module tcb_uart_tx (
  input  logic              sub,
  input  logic              rst_n,
  input  logic              vld,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  output logic              rdy,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              txd
);

  // baud counter width
  localparam int unsigned BW = $clog2(`TCB_BAUD_DIV);

  tcb_pkg::uart_state_t state;
  logic [BW-1:0]        baud_cnt;
  logic                 baud_end;
  logic [2:0]           bit_cnt;
  logic [7:0]           shifter;
  logic                 busy;
  logic                 txdata_sel;
  logic                 trn;
  logic                 load;

  //////////////////////////////
  // bus side
  //////////////////////////////

  assign busy       = (state != tcb_pkg::idle);
  // TXDATA at offset 0, STATUS at 4
  assign txdata_sel = ~adr[2];
  // stall only TXDATA writes, status reads pass
  assign rdy        = ~(wen & txdata_sel & busy);
  assign trn        = vld & rdy;
  assign load       = trn & wen & txdata_sel & ben[0];

  always_ff @(posedge sub) begin
    if (trn && !wen) rdt <= txdata_sel ? '0 : tcb_pkg::tcb_dat_t'(busy);
  end

  //////////////////////////////
  // frame FSM
  //////////////////////////////

  assign baud_end = (baud_cnt == BW'(`TCB_BAUD_DIV - 1));

  always_ff @(posedge sub) begin
    if (!rst_n) begin
      state    <= tcb_pkg::idle;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      // bit period timing
      baud_cnt <= (busy && !baud_end) ? baud_cnt + 1'b1 : '0;
      case (state)
        tcb_pkg::idle: begin
          if (load) state <= tcb_pkg::start;
        end
        tcb_pkg::start: begin
          if (baud_end) begin
            state   <= tcb_pkg::data;
            bit_cnt <= '0;
          end
        end
        tcb_pkg::data: begin
          if (baud_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            // last data bit
            if (bit_cnt == 3'd7) state <= tcb_pkg::stop;
          end
        end
        default: begin
          if (baud_end) state <= tcb_pkg::idle;
        end
      endcase
    end
  end

  // lsb goes out first
  always_ff @(posedge sub) begin
    if (load) begin
      shifter <= wdt[7:0];
    end else if (state == tcb_pkg::data && baud_end) begin
      shifter <= shifter >> 1;
    end
  end

  // registered line, one cycle behind the state
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      txd <= 1'b1;
    end else begin
      case (state)
        tcb_pkg::start: txd <= 1'b0;
        tcb_pkg::data:  txd <= shifter[0];
        // idle and stop keep the line high
        default:        txd <= 1'b1;
      endcase
    end
  end

endmodule

//--- design/tcb_periph_top.sv
// peripheral subsystem top, decoder and demultiplexer in front of RAM, timer and UART
`include "tcb_defs.svh"

module tcb_periph_top (
  input  logic                 sub,
  input  logic                 rst_n,
  // manager request
  input  logic                 vld,
  input  logic                 wen,
  input  logic [`TCB_ADR_W-1:0] adr,
  input  logic [`TCB_BEN_W-1:0] ben,
  input  logic [`TCB_DAT_W-1:0] wdt,
  // response
  output logic                 rdy,
  output logic [`TCB_DAT_W-1:0] rdt,
  output logic                 err,
  // peripheral pins
  output logic                 irq,
  output logic                 txd
);

  //////////////////////////////
  // interconnect wires
  //////////////////////////////

  logic [1:0]            sel;
  logic                  hit;

  // port 0 ram, 1 timer, 2 uart
  logic                  spn_vld [`TCB_SPN];
  logic                  spn_wen [`TCB_SPN];
  logic [`TCB_ADR_W-1:0] spn_adr [`TCB_SPN];
  logic [`TCB_BEN_W-1:0] spn_ben [`TCB_SPN];
  logic [`TCB_DAT_W-1:0] spn_wdt [`TCB_SPN];
  logic                  spn_rdy [`TCB_SPN];
  logic [`TCB_DAT_W-1:0] spn_rdt [`TCB_SPN];

  // address map
  tcb_decoder u_decoder (
    .adr (adr),
    .sel (sel),
    .hit (hit)
  );

  tcb_demultiplexer #(
    .SPN (`TCB_SPN)
  ) u_demux (
    .sub     (sub),
    .rst_n   (rst_n),
    .sel     (sel),
    .hit     (hit),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rdy     (rdy),
    .rdt     (rdt),
    .err     (err),
    .spn_vld (spn_vld),
    .spn_wen (spn_wen),
    .spn_adr (spn_adr),
    .spn_ben (spn_ben),
    .spn_wdt (spn_wdt),
    .spn_rdy (spn_rdy),
    .spn_rdt (spn_rdt)
  );

  //////////////////////////////
  // subordinates
  //////////////////////////////

  tcb_ram u_ram (
    .sub (sub),
    .vld (spn_vld[0]),
    .wen (spn_wen[0]),
    .adr (spn_adr[0]),
    .ben (spn_ben[0]),
    .wdt (spn_wdt[0]),
    .rdy (spn_rdy[0]),
    .rdt (spn_rdt[0])
  );

  tcb_timer u_timer (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (spn_vld[1]),
    .wen   (spn_wen[1]),
    .adr   (spn_adr[1]),
    .ben   (spn_ben[1]),
    .wdt   (spn_wdt[1]),
    .rdy   (spn_rdy[1]),
    .rdt   (spn_rdt[1]),
    .irq   (irq)
  );

  // only port that can stall
  tcb_uart_tx u_uart (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (spn_vld[2]),
    .wen   (spn_wen[2]),
    .adr   (spn_adr[2]),
    .ben   (spn_ben[2]),
    .wdt   (spn_wdt[2]),
    .rdy   (spn_rdy[2]),
    .rdt   (spn_rdt[2]),
    .txd   (txd)
  );

endmodule

//--- bench/tcb_periph_properties.sv
// bus and UART protocol assertions, bound into the peripheral top level for every simulation
`include "tcb_defs.svh"

module tcb_periph_properties (
  input logic                 sub,
  input logic                 rst_n,
  input logic                 vld,
  input logic                 rdy,
  input tcb_pkg::tcb_adr_t    adr,
  input logic                 err,
  input logic                 txd,
  input logic                 spn_vld [`TCB_SPN],
  input tcb_pkg::uart_state_t uart_state
);

  // failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  logic [`TCB_SPN-1:0] vld_vec;
  // request address lies inside one of the three regions
  logic                mapped;

  always_comb begin
    for (int i = 0; i < `TCB_SPN; i++) begin
      vld_vec[i] = spn_vld[i];
    end
  end

  // region bounds taken straight from the address map
  assign mapped = (adr >= `TCB_RAM_BASE && adr < `TCB_RAM_BASE + `TCB_RAM_SIZE)
               || (adr >= `TCB_TMR_BASE && adr < `TCB_TMR_BASE + `TCB_PER_SIZE)
               || (adr >= `TCB_UART_BASE && adr < `TCB_UART_BASE + `TCB_PER_SIZE);

  //////////////////////////////
  // bus
  //////////////////////////////

  // only the decoded port sees a request
  a_one_port: assert property (@(posedge sub) disable iff (!rst_n) $onehot0(vld_vec))
    else begin
      fail_cnt++;
      $error("more than one subordinate port has vld high");
    end

  // mapped transfers never answer with err
  a_no_err: assert property (@(posedge sub) disable iff (!rst_n)
    (vld && rdy && mapped) |=> !err)
    else begin
      fail_cnt++;
      $error("err is high after a transfer to a mapped address");
    end

  //////////////////////////////
  // uart line
  //////////////////////////////

  a_idle_line: assert property (@(posedge sub) disable iff (!rst_n)
    (uart_state == tcb_pkg::idle) |-> txd)
    else begin
      fail_cnt++;
      $error("txd is low while the UART is idle");
    end

endmodule

bind tcb_periph_top tcb_periph_properties u_props (
  .sub        (sub),
  .rst_n      (rst_n),
  .vld        (vld),
  .rdy        (rdy),
  .adr        (adr),
  .err        (err),
  .txd        (txd),
  .spn_vld    (spn_vld),
  .uart_state (u_uart.state)
);

//--- bench/tcb_periph_tb.sv
// directed testbench for the peripheral subsystem; it is the single bus manager of tcb_periph_top
`include "tcb_defs.svh"

module tcb_periph_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int BIT_CYCLES   = `TCB_BAUD_DIV;
  // start bit, 8 data bits, stop bit
  localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
  // run budget in clock periods
  localparam int N_FRAMES     = 4;
  localparam int N_BUS_OPS    = 81;
  localparam int MARGIN       = 100;
  localparam int TIMEOUT      = (N_FRAMES * FRAME_CYCLES + N_BUS_OPS + MARGIN) * CLK_PERIOD;

  // register map
  localparam tcb_pkg::tcb_adr_t TMR_CTRL    = `TCB_TMR_BASE + 16'h0;
  localparam tcb_pkg::tcb_adr_t TMR_CMP     = `TCB_TMR_BASE + 16'h4;
  localparam tcb_pkg::tcb_adr_t TMR_CNT     = `TCB_TMR_BASE + 16'h8;
  localparam tcb_pkg::tcb_adr_t TMR_STATUS  = `TCB_TMR_BASE + 16'hc;
  localparam tcb_pkg::tcb_adr_t UART_TXDATA = `TCB_UART_BASE + 16'h0;
  localparam tcb_pkg::tcb_adr_t UART_STATUS = `TCB_UART_BASE + 16'h4;
  // outside every region
  localparam tcb_pkg::tcb_adr_t UNMAPPED    = 16'h3000;

  logic              sub;
  logic              rst_n;
  logic              vld;
  logic              wen;
  tcb_pkg::tcb_adr_t adr;
  tcb_pkg::tcb_ben_t ben;
  tcb_pkg::tcb_dat_t wdt;
  logic              rdy;
  tcb_pkg::tcb_dat_t rdt;
  logic              err;
  logic              irq;
  logic              txd;

  logic [31:0]       lfsr = 32'h7381;
  // expected RAM words and the word indices in use
  tcb_pkg::tcb_dat_t shadow [`TCB_RAM_DEPTH];
  logic [7:0]        ram_idx [16];

  tcb_periph_top u_dut (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .ben   (ben),
    .wdt   (wdt),
    .rdy   (rdy),
    .rdt   (rdt),
    .err   (err),
    .irq   (irq),
    .txd   (txd)
  );

  initial begin
    sub = 1'b0;
    forever #(CLK_PERIOD / 2) sub = ~sub;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic tcb_pkg::tcb_dat_t rand_bits(input int n);
    tcb_pkg::tcb_dat_t val;
    logic              fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic tcb_pkg::tcb_adr_t ram_adr(input logic [7:0] idx);
    return `TCB_RAM_BASE | tcb_pkg::tcb_adr_t'({idx, 2'b00});
  endfunction

  task automatic stop_on_failure();
    $display("Finished with errors");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic expect_value(input string test, input tcb_pkg::tcb_dat_t exp,
                              input tcb_pkg::tcb_dat_t act);
    assert (act === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic expect_true(input string test, input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test, what);
      stop_on_failure();
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge sub);
  endtask

  // called at a falling edge, returns at the falling edge after the response cycle starts
  task automatic bus_xfer(input logic wr, input tcb_pkg::tcb_adr_t a,
                          input tcb_pkg::tcb_ben_t b, input tcb_pkg::tcb_dat_t d,
                          output tcb_pkg::tcb_dat_t rd, output logic e, output int stalls);
    logic done;
    stalls = 0;
    done   = 1'b0;
    vld    = 1'b1;
    wen    = wr;
    adr    = a;
    ben    = b;
    wdt    = d;
    while (!done) begin
      // rdy is settled in the low phase
      #(CLK_PERIOD / 4);
      done = rdy;
      if (!done) stalls++;
      @(negedge sub);
    end
    // response of the edge just passed
    rd  = rdt;
    e   = err;
    vld = 1'b0;
    wen = 1'b0;
  endtask

  task automatic bus_write(input tcb_pkg::tcb_adr_t a, input tcb_pkg::tcb_ben_t b,
                           input tcb_pkg::tcb_dat_t d, output logic e, output int stalls);
    tcb_pkg::tcb_dat_t rd_ignored;
    bus_xfer(1'b1, a, b, d, rd_ignored, e, stalls);
  endtask

  task automatic bus_read(input tcb_pkg::tcb_adr_t a, output tcb_pkg::tcb_dat_t rd,
                          output logic e, output int stalls);
    bus_xfer(1'b0, a, '1, '0, rd, e, stalls);
  endtask

  task automatic shadow_write(input logic [7:0] idx, input tcb_pkg::tcb_ben_t b,
                              input tcb_pkg::tcb_dat_t d);
    for (int k = 0; k < `TCB_BEN_W; k++) begin
      if (b[k]) shadow[idx][8*k +: 8] = d[8*k +: 8];
    end
  endtask

  task automatic compare_ram(input string test);
    tcb_pkg::tcb_dat_t rd;
    logic              e;
    int                stalls;
    for (int i = 0; i < 16; i++) begin
      bus_read(ram_adr(ram_idx[i]), rd, e, stalls);
      expect_value(test, shadow[ram_idx[i]], rd);
    end
  endtask

  // starts at the falling edge right after the TXDATA transfer
  task automatic verify_frame(input string test, input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    // line falls one edge after the load, then sample mid bit
    repeat (1 + BIT_CYCLES / 2) @(negedge sub);
    for (int k = 0; k < 10; k++) begin
      if (k > 0) repeat (BIT_CYCLES) @(negedge sub);
      expect_value(test, tcb_pkg::tcb_dat_t'(frame[k]), tcb_pkg::tcb_dat_t'(txd));
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic test_ram();
    tcb_pkg::tcb_dat_t d;
    tcb_pkg::tcb_ben_t b;
    logic [7:0]        idx;
    logic              e;
    int                stalls;
    // full words first so every byte read back is defined
    for (int i = 0; i < 16; i++) begin
      idx        = 8'(rand_bits(8));
      ram_idx[i] = idx;
      d          = rand_bits(32);
      bus_write(ram_adr(idx), 4'hf, d, e, stalls);
      shadow_write(idx, 4'hf, d);
    end
    // then partial updates over the same words
    for (int i = 0; i < 16; i++) begin
      idx = ram_idx[4'(rand_bits(4))];
      b   = 4'(rand_bits(4));
      d   = rand_bits(32);
      bus_write(ram_adr(idx), b, d, e, stalls);
      shadow_write(idx, b, d);
    end
    compare_ram("test_ram");
  endtask

  task automatic test_unmapped();
    tcb_pkg::tcb_dat_t rd;
    logic              e;
    int                stalls;
    bus_read(UNMAPPED, rd, e, stalls);
    expect_value("test_unmapped", 32'd1, tcb_pkg::tcb_dat_t'(e));
    expect_value("test_unmapped", 32'd0, tcb_pkg::tcb_dat_t'(stalls));
    bus_write(UNMAPPED, 4'hf, rand_bits(32), e, stalls);
    expect_value("test_unmapped", 32'd1, tcb_pkg::tcb_dat_t'(e));
    expect_value("test_unmapped", 32'd0, tcb_pkg::tcb_dat_t'(stalls));
    compare_ram("test_unmapped");
  endtask

  task automatic test_timer();
    tcb_pkg::tcb_dat_t rd;
    logic              e;
    int                stalls;
    bus_write(TMR_CMP, 4'hf, 32'd20, e, stalls);
    bus_write(TMR_CTRL, 4'hf, 32'd1, e, stalls);
    // counts 0 to 20, match on the next step
    for (int i = 0; i < 25; i++) begin
      if (irq) break;
      @(negedge sub);
    end
    expect_true("test_timer", irq, "irq did not rise within 25 cycles");
    bus_write(TMR_STATUS, 4'hf, 32'd1, e, stalls);
    expect_value("test_timer", 32'd0, tcb_pkg::tcb_dat_t'(irq));
    bus_read(TMR_CNT, rd, e, stalls);
    expect_true("test_timer", rd <= 32'd20, "counter readback is above the compare value");
  endtask

  task automatic test_uart();
    logic [7:0] data;
    logic       e;
    int         stalls;
    data = 8'(rand_bits(8));
    bus_write(UART_TXDATA, 4'hf, tcb_pkg::tcb_dat_t'(data), e, stalls);
    expect_value("test_uart", 32'd0, tcb_pkg::tcb_dat_t'(stalls));
    verify_frame("test_uart", data);
    idle_cycles(BIT_CYCLES);
  endtask

  task automatic test_uart_backpressure();
    logic [7:0]        first;
    logic [7:0]        second;
    tcb_pkg::tcb_dat_t rd;
    logic              e;
    int                stalls;
    first  = 8'(rand_bits(8));
    second = 8'(rand_bits(8));
    bus_write(UART_TXDATA, 4'hf, tcb_pkg::tcb_dat_t'(first), e, stalls);
    fork
      bus_write(UART_TXDATA, 4'hf, tcb_pkg::tcb_dat_t'(second), e, stalls);
      verify_frame("test_uart_backpressure", first);
    join
    // second load waits out every bit period of the first frame
    expect_value("test_uart_backpressure", FRAME_CYCLES, tcb_pkg::tcb_dat_t'(stalls));
    fork
      verify_frame("test_uart_backpressure", second);
      begin
        bus_read(UART_STATUS, rd, e, stalls);
        expect_value("test_uart_backpressure", 32'd1, rd);
      end
    join
    idle_cycles(BIT_CYCLES);
    bus_read(UART_STATUS, rd, e, stalls);
    expect_value("test_uart_backpressure", 32'd0, rd);
  endtask

  task automatic test_routing();
    logic [7:0]        data;
    tcb_pkg::tcb_dat_t rd;
    logic              e;
    int                stalls;
    data = 8'(rand_bits(8));
    bus_write(UART_TXDATA, 4'hf, tcb_pkg::tcb_dat_t'(data), e, stalls);
    fork
      verify_frame("test_routing", data);
      begin
        // other ports answer at once while the UART is busy
        for (int i = 0; i < 4; i++) begin
          bus_read(ram_adr(ram_idx[i]), rd, e, stalls);
          expect_value("test_routing", shadow[ram_idx[i]], rd);
          expect_value("test_routing", 32'd0, tcb_pkg::tcb_dat_t'(stalls));
        end
        bus_read(TMR_CMP, rd, e, stalls);
        expect_value("test_routing", 32'd20, rd);
        expect_value("test_routing", 32'd0, tcb_pkg::tcb_dat_t'(stalls));
      end
    join
    idle_cycles(BIT_CYCLES);
  endtask

  //////////////////////////////
  // sequence and watchdog
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    ben   = '0;
    wdt   = '0;
    repeat (5) @(negedge sub);
    rst_n = 1'b1;
    test_ram();
    test_unmapped();
    test_timer();
    test_uart();
    test_uart_backpressure();
    test_routing();
    idle_cycles(2);
    if (u_dut.u_props.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("%0d bound assertion failures during the run", u_dut.u_props.fail_cnt);
      stop_on_failure();
    end
  end

  initial begin
    #(TIMEOUT);
    $display("timeout, the tests did not finish within %0d time units", TIMEOUT);
    stop_on_failure();
  end

endmodule

//--- tcb_periph.f
+incdir+design
design/tcb_pkg.sv
design/tcb_decoder.sv
design/tcb_demultiplexer.sv
design/tcb_ram.sv
design/tcb_timer.sv
design/tcb_uart_tx.sv
design/tcb_periph_top.sv
bench/tcb_periph_properties.sv
bench/tcb_periph_tb.sv
